//--- milli_timer.sv
`timescale 1ns/1ps

module milli_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] ticks_per_milli,
  output logic        milli_tick
);

  logic [15:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= ticks_per_milli - 16'd1;
    end else if (count == '0) begin
      count <= ticks_per_milli - 16'd1;  // reload at every tick
    end else begin
      count <= count - 16'd1;
    end
  end

  // count never hits zero in reset since ticks_per_milli >= 2
  assign milli_tick = (count == '0);

endmodule

//--- music_pkg.sv
package music_pkg;

  typedef logic [9:0] freq_t;      // hz where zero is silence
  typedef logic [3:0] beats_t;
  typedef logic [2:0] part_t;
  typedef logic [3:0] note_idx_t;
  typedef logic [6:0] seg_t;       // bit 0 is the top segment

  typedef struct packed {
    freq_t  freq;
    beats_t beats;
  } note_t;

  typedef enum logic [1:0] {
    SEC_INTRO,
    SEC_VERSE,
    SEC_CHORUS
  } section_t;

  localparam part_t FIRST_PART = 3'd1;
  localparam part_t LAST_PART  = 3'd6;

  localparam int VERSE_STRETCH  = 2;
  localparam int GAP_DIVISOR    = 3;
  localparam int HALF_PERIOD_MS = 500;

  // segment g in bit 6
  localparam seg_t SEG_DIGITS [0:9] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
    7'b1101101, 7'b1111100, 7'b0000111, 7'b1111111, 7'b1100111
  };

  // song order is intro, intro, verse, chorus, verse, chorus
  function automatic section_t section_of(part_t part);
    case (part)
      3'd3, 3'd5: return SEC_VERSE;
      3'd4, 3'd6: return SEC_CHORUS;
      default:    return SEC_INTRO;
    endcase
  endfunction

  function automatic seg_t seg_digit(logic [3:0] value);
    if (value <= 4'd9) return SEG_DIGITS[value];
    return '0;  // blank for non-decimal values
  endfunction

endpackage

//--- music_player.sv
`timescale 1ns/1ps

module music_player
  import music_pkg::*;
#(
  parameter int BEAT_MS = 100,  // tempo
  parameter int MILLI_W = 12
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] ticks_per_milli,
  output logic [7:0]  led,
  output logic        sound
);

  logic      milli_tick;
  part_t     part;
  note_idx_t note_idx;
  note_idx_t last_idx;
  note_t     note;
  freq_t     freq;
  logic      playing;

  milli_timer i_milli_timer (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .milli_tick      (milli_tick)
  );

  song_rom i_song_rom (
    .part     (part),
    .note_idx (note_idx),
    .note     (note),
    .last_idx (last_idx)
  );

  note_sequencer #(
    .BEAT_MS (BEAT_MS),
    .MILLI_W (MILLI_W)
  ) i_note_sequencer (
    .clk        (clk),
    .rst        (rst),
    .milli_tick (milli_tick),
    .note       (note),
    .last_idx   (last_idx),
    .part       (part),
    .note_idx   (note_idx),
    .freq       (freq),
    .playing    (playing)
  );

  tone_generator i_tone_generator (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .freq            (freq),
    .sound           (sound)
  );

  segment_display i_segment_display (
    .part    (part),
    .playing (playing),
    .led     (led)
  );

endmodule

//--- music_player_props.sv
`timescale 1ns/1ps

module music_player_props
  import music_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input freq_t freq,
  input part_t part,
  input logic  playing,
  input logic  sound
);

  // a zero frequency holds the square wave low
  property quiet_while_silent;
    @(posedge clk) disable iff (rst) (freq == '0) |=> (sound == 1'b0);
  endproperty

  property part_in_range;
    @(posedge clk) disable iff (rst) (part >= FIRST_PART && part <= LAST_PART);
  endproperty

  property idle_after_reset;
    @(posedge clk) $fell(rst) |-> !playing;
  endproperty

  a_quiet: assert property (quiet_while_silent)
    else $error("sound changed while freq is zero");
  a_part: assert property (part_in_range)
    else $error("part left the range 1 to 6");
  a_idle: assert property (idle_after_reset)
    else $error("playing high in the cycle after reset");

endmodule

// sequencer and tone generator signals meet at the top level
bind music_player music_player_props i_player_props (
  .clk     (clk),
  .rst     (rst),
  .freq    (freq),
  .part    (part),
  .playing (playing),
  .sound   (sound)
);

//--- note_sequencer.sv
`timescale 1ns/1ps

module note_sequencer
  import music_pkg::*;
#(
  parameter int BEAT_MS = 100,
  parameter int MILLI_W = 12
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      milli_tick,
  input  note_t     note,
  input  note_idx_t last_idx,
  output part_t     part,
  output note_idx_t note_idx,
  output freq_t     freq,
  output logic      playing
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_PLAY,
    ST_GAP
  } state_t;

  state_t             state;
  logic [MILLI_W-1:0] ms_cnt;     // ticks seen in the current phase
  logic [MILLI_W-1:0] note_len;
  logic [MILLI_W-1:0] base_len;
  logic [MILLI_W-1:0] fetch_len;
  logic [MILLI_W-1:0] gap_len;
  logic [MILLI_W-1:0] span;
  logic               span_done;
  logic               advance;
  part_t              next_part;

  assign base_len  = MILLI_W'(note.beats) * MILLI_W'(BEAT_MS);
  assign fetch_len = (section_of(part) == SEC_VERSE) ?
                     base_len * MILLI_W'(VERSE_STRETCH) : base_len;
  assign gap_len   = note_len / MILLI_W'(GAP_DIVISOR);  // rounds down

  // one counter times both play and gap
  assign span      = (state == ST_PLAY) ? note_len : gap_len;
  assign span_done = milli_tick && (ms_cnt == span - MILLI_W'(1));

  // move on after the gap, or straight after play when the gap is empty
  assign advance   = span_done &&
                     ((state == ST_GAP) || (state == ST_PLAY && gap_len == '0));
  assign next_part = (part == LAST_PART) ? FIRST_PART : part + 3'd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_FETCH;
      part     <= FIRST_PART;
      note_idx <= '0;
      ms_cnt   <= '0;
      freq     <= '0;
      playing  <= 1'b0;
    end else begin
      if (advance) begin
        if (note_idx == last_idx) begin
          note_idx <= '0;
          part     <= next_part;  // wraps 6 -> 1
        end else begin
          note_idx <= note_idx + 4'd1;
        end
      end
      case (state)
        ST_FETCH: begin
          freq    <= note.freq;   // zero for a rest
          playing <= 1'b1;
          ms_cnt  <= '0;
          state   <= ST_PLAY;
        end
        ST_PLAY: begin
          if (span_done) begin
            freq    <= '0;
            playing <= 1'b0;
            ms_cnt  <= '0;
            state   <= (gap_len == '0) ? ST_FETCH : ST_GAP;
          end else if (milli_tick) begin
            ms_cnt <= ms_cnt + MILLI_W'(1);
          end
        end
        ST_GAP: begin
          if (span_done) begin
            ms_cnt <= '0;
            state  <= ST_FETCH;
          end else if (milli_tick) begin
            ms_cnt <= ms_cnt + MILLI_W'(1);
          end
        end
        default: state <= ST_FETCH;
      endcase
    end
  end

  // length latched with the note
  always_ff @(posedge clk) begin
    if (state == ST_FETCH) begin
      note_len <= fetch_len;
    end
  end

endmodule

//--- project.f
music_pkg.sv
milli_timer.sv
tone_generator.sv
song_rom.sv
note_sequencer.sv
segment_display.sv
music_player.sv
music_player_props.sv
tb_music_player.sv

//--- run.sh
#!/bin/sh
# Build and run the music player testbench with Verilator.
# Exit status is nonzero when the build, the run or the testbench fails.

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_music_player \
  --Mdir obj_dir -o tb_music_player \
  -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_music_player > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

//--- segment_display.sv
`timescale 1ns/1ps

module segment_display
  import music_pkg::*;
(
  input  part_t      part,
  input  logic       playing,
  output logic [7:0] led
);

  logic [3:0] digit;
  seg_t       segments;

  assign digit    = {1'b0, part};
  assign segments = seg_digit(digit);  // part number as a decimal digit

  // dot lit while a note or rest is playing
  assign led = {playing, segments};

endmodule

//--- song_rom.sv
`timescale 1ns/1ps

module song_rom
  import music_pkg::*;
(
  input  part_t     part,
  input  note_idx_t note_idx,
  output note_t     note,
  output note_idx_t last_idx
);

  always_comb begin
    note     = '{10'd0, 4'd0};
    last_idx = '0;
    case (section_of(part))
      SEC_INTRO: begin
        last_idx = 4'd12;
        case (note_idx)
          4'd0:  note = '{10'd554, 4'd6};   // c#5
          4'd1:  note = '{10'd622, 4'd10};  // eb5
          4'd2:  note = '{10'd622, 4'd6};
          4'd3:  note = '{10'd698, 4'd6};   // f5
          4'd4:  note = '{10'd831, 4'd1};   // ab5
          4'd5:  note = '{10'd740, 4'd1};   // f#5
          4'd6:  note = '{10'd698, 4'd1};
          4'd7:  note = '{10'd622, 4'd1};
          4'd8:  note = '{10'd554, 4'd6};
          4'd9:  note = '{10'd622, 4'd10};
          4'd10: note = '{10'd0,   4'd4};   // rest
          4'd11: note = '{10'd415, 4'd2};   // ab4
          4'd12: note = '{10'd415, 4'd10};
          default: note = '{10'd0, 4'd0};
        endcase
      end
      SEC_VERSE: begin
        last_idx = 4'd15;
        case (note_idx)
          4'd0:  note = '{10'd0,   4'd6};   // opening rest
          4'd1:  note = '{10'd277, 4'd1};   // c#4
          4'd2:  note = '{10'd277, 4'd1};
          4'd3:  note = '{10'd277, 4'd1};
          4'd4:  note = '{10'd277, 4'd1};
          4'd5:  note = '{10'd311, 4'd2};   // eb4
          4'd6:  note = '{10'd0,   4'd1};
          4'd7:  note = '{10'd261, 4'd1};   // c4
          4'd8:  note = '{10'd233, 4'd1};   // bb3
          4'd9:  note = '{10'd208, 4'd5};   // ab3
          4'd10: note = '{10'd0,   4'd1};
          4'd11: note = '{10'd233, 4'd1};
          4'd12: note = '{10'd233, 4'd1};
          4'd13: note = '{10'd261, 4'd1};
          4'd14: note = '{10'd277, 4'd3};
          default: note = '{10'd208, 4'd1};  // index 15
        endcase
      end
      default: begin  // chorus
        last_idx = 4'd15;
        case (note_idx)
          4'd0:  note = '{10'd466, 4'd1};   // bb4
          4'd1:  note = '{10'd466, 4'd1};
          4'd2:  note = '{10'd415, 4'd1};
          4'd3:  note = '{10'd415, 4'd1};
          4'd4:  note = '{10'd698, 4'd3};
          4'd5:  note = '{10'd698, 4'd3};
          4'd6:  note = '{10'd622, 4'd6};
          4'd7:  note = '{10'd466, 4'd1};
          4'd8:  note = '{10'd466, 4'd1};
          4'd9:  note = '{10'd415, 4'd1};
          4'd10: note = '{10'd415, 4'd1};
          4'd11: note = '{10'd622, 4'd3};
          4'd12: note = '{10'd622, 4'd3};
          4'd13: note = '{10'd554, 4'd3};
          4'd14: note = '{10'd523, 4'd1};   // c5
          default: note = '{10'd466, 4'd2};  // index 15
        endcase
      end
    endcase
  end

endmodule

//--- tb_music_player.sv
`timescale 1ns/1ps

module tb_music_player
  import music_pkg::*;
();

  localparam int BEAT_MS     = 2;
  localparam int TPM         = 8;          // clock cycles per millisecond
  localparam int HALF_CYCLES = TPM * 500;  // cycles in half a second
  localparam int PITCH_PICKS = 4;

  // copy of the song tables
  localparam int INTRO_FREQ   [0:12] = '{554, 622, 622, 698, 831, 740, 698,
                                         622, 554, 622, 0, 415, 415};
  localparam int INTRO_BEATS  [0:12] = '{6, 10, 6, 6, 1, 1, 1, 1, 6, 10, 4, 2, 10};
  localparam int VERSE_FREQ   [0:15] = '{0, 277, 277, 277, 277, 311, 0, 261,
                                         233, 208, 0, 233, 233, 261, 277, 208};
  localparam int VERSE_BEATS  [0:15] = '{6, 1, 1, 1, 1, 2, 1, 1, 1, 5, 1, 1, 1, 1, 3, 1};
  localparam int CHORUS_FREQ  [0:15] = '{466, 466, 415, 415, 698, 698, 622, 466,
                                         466, 415, 415, 622, 622, 554, 523, 466};
  localparam int CHORUS_BEATS [0:15] = '{1, 1, 1, 1, 3, 3, 6, 1, 1, 1, 1, 3, 3, 3, 1, 2};

  logic        clk;
  logic        rst;
  logic [15:0] ticks_per_milli;
  logic [7:0]  led;
  logic        sound;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  int          cycle_limit;
  int unsigned seed_value;

  music_player #(
    .BEAT_MS (BEAT_MS),
    .MILLI_W (12)
  ) i_music_player (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .led             (led),
    .sound           (sound)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // 0 intro, 1 verse, 2 chorus
  function automatic int part_section(int part);
    case (part)
      3, 5:    return 1;
      4, 6:    return 2;
      default: return 0;
    endcase
  endfunction

  function automatic int part_notes(int part);
    return (part_section(part) == 0) ? 13 : 16;
  endfunction

  function automatic int note_beats(int part, int idx);
    case (part_section(part))
      0:       return INTRO_BEATS[4'(idx)];
      1:       return VERSE_BEATS[4'(idx)];
      default: return CHORUS_BEATS[4'(idx)];
    endcase
  endfunction

  function automatic int note_freq(int part, int idx);
    case (part_section(part))
      0:       return INTRO_FREQ[4'(idx)];
      1:       return VERSE_FREQ[4'(idx)];
      default: return CHORUS_FREQ[4'(idx)];
    endcase
  endfunction

  function automatic int play_ms(int part, int idx);
    int ms;
    ms = note_beats(part, idx) * BEAT_MS;
    if (part_section(part) == 1) ms = ms * 2;  // verse stretch
    return ms;
  endfunction

  function automatic seg_t digit_pattern(int value);
    case (value)
      1:       return 7'b0000110;
      2:       return 7'b1011011;
      3:       return 7'b1001111;
      4:       return 7'b1100110;
      5:       return 7'b1101101;
      6:       return 7'b1111100;
      default: return 7'b0000000;
    endcase
  endfunction

  // play, gap and two fetch cycles for every note
  function automatic int song_cycles();
    int total;
    total = 0;
    for (int part = 1; part <= 6; part++) begin
      for (int idx = 0; idx < part_notes(part); idx++) begin
        total += (play_ms(part, idx) + play_ms(part, idx) / 3) * TPM + 2;
      end
    end
    return total;
  endfunction

  task automatic compare_seg(string name, seg_t expected, seg_t actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_led(string name, logic [7:0] expected, logic [7:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic cycles_within(string name, int lo, int hi, int actual);
    if (actual < lo || actual > hi) begin
      $display("FAIL %0t %s expected %0d to %0d got %0d", $time, name, lo, hi, actual);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  // returns at the first negedge with the dot lit
  task automatic wait_dot_rise();
    @(negedge clk);
    while (led[7] !== 1'b0) @(negedge clk);
    while (led[7] !== 1'b1) @(negedge clk);
  endtask

  // counts the dot-high cycles and the sound toggle spacing
  task automatic measure_high(output int high, output int n_iv, output int min_iv,
                              output int max_iv, output logic seen);
    logic prev_sound;
    int   last_toggle;
    int   n_toggles;
    int   iv;
    high        = 0;
    n_iv        = 0;
    min_iv      = 1 << 30;
    max_iv      = 0;
    seen        = 1'b0;
    n_toggles   = 0;
    last_toggle = 0;
    prev_sound  = sound;
    while (led[7] === 1'b1) begin
      if (sound === 1'b1) seen = 1'b1;
      if (sound !== prev_sound) begin
        if (n_toggles > 0) begin
          iv = high - last_toggle;
          if (iv < min_iv) min_iv = iv;
          if (iv > max_iv) max_iv = iv;
          n_iv++;
        end
        n_toggles++;
        last_toggle = high;
      end
      prev_sound = sound;
      high++;
      @(negedge clk);
    end
  endtask

  task automatic measure_low(output int low);
    low = 0;
    while (led[7] === 1'b0) begin
      low++;
      @(negedge clk);
    end
  endtask

  task automatic skip_notes(int count);
    int   high;
    int   n_iv;
    int   min_iv;
    int   max_iv;
    int   low;
    logic seen;
    repeat (count) begin
      measure_high(high, n_iv, min_iv, max_iv, seen);
      measure_low(low);
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic reset_values();
    int errors_before;
    errors_before = errors;
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      expect_bit("sound", 1'b0, sound);
      check_led("led", {1'b0, digit_pattern(1)}, led);
      @(posedge clk);
    end
    rst <= 1'b0;
    @(negedge clk);  // first cycle out of reset
    expect_bit("sound", 1'b0, sound);
    check_led("led", {1'b0, digit_pattern(1)}, led);
    finish_test("reset", errors_before);
  endtask

  task automatic pitch_intervals();
    int   errors_before;
    int   idx;
    int   period;
    int   high;
    int   n_iv;
    int   min_iv;
    int   max_iv;
    logic seen;
    errors_before = errors;
    for (int pick = 0; pick < PITCH_PICKS; pick++) begin
      idx = $urandom % 13;
      while (note_freq(1, idx) == 0) idx = $urandom % 13;  // skip the rest
      period = HALF_CYCLES / note_freq(1, idx);
      apply_reset();
      wait_dot_rise();
      skip_notes(idx);
      measure_high(high, n_iv, min_iv, max_iv, seen);
      if (n_iv == 0) begin
        $display("ERROR: intro note %0d gave fewer than two sound toggles", idx);
        errors++;
      end else begin
        cycles_within("sound toggle interval", period, period + 1, min_iv);
        cycles_within("sound toggle interval", period, period + 1, max_iv);
      end
    end
    finish_test("pitch", errors_before);
  endtask

  task automatic note_and_gap_timing();
    int   errors_before;
    int   ms;
    int   high;
    int   low;
    int   n_iv;
    int   min_iv;
    int   max_iv;
    logic seen;
    errors_before = errors;
    apply_reset();
    wait_dot_rise();
    for (int idx = 0; idx < part_notes(1); idx++) begin
      ms = play_ms(1, idx);
      measure_high(high, n_iv, min_iv, max_iv, seen);
      cycles_within("dot high", (ms - 1) * TPM, (ms + 1) * TPM, high);
      measure_low(low);
      cycles_within("dot low", (ms / 3 - 1) * TPM, (ms / 3 + 1) * TPM, low);
    end
    finish_test("note and gap timing", errors_before);
  endtask

  task automatic rest_silence();
    int   errors_before;
    int   ms;
    int   high;
    int   n_iv;
    int   min_iv;
    int   max_iv;
    logic seen;
    errors_before = errors;
    ms = play_ms(1, 10);
    apply_reset();
    wait_dot_rise();
    skip_notes(10);
    measure_high(high, n_iv, min_iv, max_iv, seen);
    expect_bit("sound during rest", 1'b0, seen);
    cycles_within("rest dot high", (ms - 1) * TPM, (ms + 1) * TPM, high);
    finish_test("rest", errors_before);
  endtask

  task automatic part_progression();
    int   errors_before;
    int   ms;
    int   high;
    int   low;
    int   n_iv;
    int   min_iv;
    int   max_iv;
    logic seen;
    errors_before = errors;
    apply_reset();
    wait_dot_rise();
    for (int part = 1; part <= 6; part++) begin
      for (int idx = 0; idx < part_notes(part); idx++) begin
        compare_seg("led segments", digit_pattern(part), led[6:0]);
        measure_high(high, n_iv, min_iv, max_iv, seen);
        if (part_section(part) == 1) begin
          ms = 2 * note_beats(part, idx) * BEAT_MS;
          cycles_within("verse dot high", (ms - 1) * TPM, (ms + 1) * TPM, high);
        end
        measure_low(low);
      end
    end
    compare_seg("led segments", digit_pattern(1), led[6:0]);  // song wrapped
    finish_test("part progression", errors_before);
  endtask

  initial begin
    cycle_count = 0;
    cycle_limit = 3 * song_cycles();  // about three full songs
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests still running after %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst             = 1'b1;
    ticks_per_milli = 16'(TPM);
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    seed_value      = 32'h8ced;
    void'($urandom(seed_value));
    reset_values();
    pitch_intervals();
    note_and_gap_timing();
    rest_silence();
    part_progression();
    $display("summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tone_generator.sv
`timescale 1ns/1ps

module tone_generator
  import music_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] ticks_per_milli,
  input  freq_t       freq,
  output logic        sound
);

  localparam int ACC_W = 26;  // holds 65535 * 500 plus one step

  logic [ACC_W-1:0] half_period;
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_step;

  // cycles per half second
  assign half_period = ACC_W'(ticks_per_milli) * ACC_W'(HALF_PERIOD_MS);
  assign acc_step    = acc + ACC_W'(freq);

  always_ff @(posedge clk) begin
    if (rst || freq == '0) begin
      acc   <= '0;
      sound <= 1'b0;  // silent and phase restarted
    end else if (acc >= half_period) begin
      acc   <= acc_step - half_period;
      sound <= ~sound;
    end else begin
      acc <= acc_step;
    end
  end

endmodule
